/* Bender.yml */
package:
  name: plat_ctrl

sources:
  - verilog/plat_ctrl_pkg.sv
  - verilog/plat_ctrl_regs.sv
  - verilog/periph_clken_gen.sv
  - verilog/domain_rst_seq.sv
  - verilog/plat_ctrl_top.sv
  - target: simulation
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_plat_ctrl.sv

/* sim.f */
verilog/plat_ctrl_pkg.sv
verilog/plat_ctrl_regs.sv
verilog/periph_clken_gen.sv
verilog/domain_rst_seq.sv
verilog/plat_ctrl_top.sv
verif/tb_clk_gen.sv
verif/tb_plat_ctrl.sv

/* verif/tb_clk_gen.sv */
//--------------------
// Testbench clock and power-on reset source. Drives the master
// clock and holds arst_n low for a set number of cycles.
//--------------------
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 16
) (
  output logic clk,
  output logic arst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release lines up with a rising edge
  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* verif/tb_plat_ctrl.sv */
//--------------------
// Testbench for the platform controller. Drives AXI4-Lite with
// random response stalls, keeps a register model, and checks reset
// state, register access, clock-enable rates and reset sequencing.
//--------------------
`default_nettype none

module tb_plat_ctrl;
  timeunit 1ns;
  timeprecision 1ps;
  import plat_ctrl_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RST_HOLD   = 8;
  localparam int NUM_CH     = NUM_DOMAINS + 1;
  localparam int SEL_W      = NUM_DOMAINS * $bits(clk_div_sel_t);
  localparam int HS_LIMIT   = 32;
  localparam int TXN_CYCLES = 16;
  localparam int N_REG_ITER = 20;
  localparam int N_ERR_ITER = 4;
  localparam int N_CLK_ITER = 6;
  localparam int N_SW_ITER  = 6;
  localparam int N_SYS_ITER = 9;
  localparam int PLANNED_CYCLES = 24 + 5 * TXN_CYCLES
    + (N_REG_ITER + N_ERR_ITER) * 2 * TXN_CYCLES + 4 * TXN_CYCLES
    + N_CLK_ITER * (2 * TXN_CYCLES + 128)
    + N_SW_ITER * (RST_HOLD + 16 + 2 * TXN_CYCLES)
    + N_SYS_ITER * (TXN_CYCLES + RST_HOLD + 8);
  localparam int WATCHDOG_CYCLES = PLANNED_CYCLES * 4;
  localparam int HS_AW = 0;
  localparam int HS_B  = 1;
  localparam int HS_AR = 2;
  localparam int HS_R  = 3;

  logic         clk;
  logic         arst_n;
  axil_req_t    axil_req;
  axil_rsp_t    axil_rsp;
  logic         sys_reset_req;
  logic         lockup;
  logic         wdog_reset_req;
  domain_mask_t clken;
  domain_mask_t domain_rst_n;
  logic         cpu_sys_rst_n;

  // Register model
  logic [SEL_W-1:0] m_sel;
  domain_mask_t     m_gate;
  domain_mask_t     m_en;
  logic             m_lockup;

  axil_addr_t        addr;
  axil_data_t        data;
  axil_data_t        rdata;
  axil_resp_t        resp;
  domain_mask_t      mask;
  logic              lock_en;
  int                src;
  int                err_cnt;
  int                en_cnt [NUM_DOMAINS];
  int                low_cnt [NUM_CH];
  int                low_runs [NUM_CH];

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(16)) u_clk_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  plat_ctrl_top #(.RST_HOLD_CYCLES(RST_HOLD)) u_dut (
    .master_clk     (clk),
    .arst_n         (arst_n),
    .axil_req       (axil_req),
    .axil_rsp       (axil_rsp),
    .sys_reset_req  (sys_reset_req),
    .lockup         (lockup),
    .wdog_reset_req (wdog_reset_req),
    .clken          (clken),
    .domain_rst_n   (domain_rst_n),
    .cpu_sys_rst_n  (cpu_sys_rst_n)
  );

  //--------------------
  // Reporting
  //--------------------
  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  //--------------------
  // AXI4-Lite driver
  //--------------------
  function automatic logic rsp_flag(input int which);
    case (which)
      HS_AW:   return axil_rsp.awready;
      HS_B:    return axil_rsp.bvalid;
      HS_AR:   return axil_rsp.arready;
      default: return axil_rsp.rvalid;
    endcase
  endfunction

  task automatic wait_handshake(input int which, input string what);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!rsp_flag(which)) begin
      waited++;
      if (waited > HS_LIMIT) begin
        $display("Timed out waiting for %s", what);
        abort_run();
      end
      @(negedge clk);
    end
  endtask

  task automatic axil_write(input axil_addr_t a, input axil_data_t d, output axil_resp_t r);
    int delay;
    delay = $urandom_range(0, 3);
    @(posedge clk);
    axil_req.awaddr  <= a;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata   <= d;
    axil_req.wstrb   <= '1;
    axil_req.wvalid  <= 1'b1;
    wait_handshake(HS_AW, "write address and data acceptance");
    // Address and data are taken together
    check_value("wready", axil_rsp.wready, 1'b1);
    @(posedge clk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    // Stall the response channel
    repeat (delay) @(posedge clk);
    wait_handshake(HS_B, "write response");
    r = axil_rsp.bresp;
    @(posedge clk);
    axil_req.bready <= 1'b1;
    @(posedge clk);
    axil_req.bready <= 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t a, output axil_data_t d, output axil_resp_t r);
    int delay;
    delay = $urandom_range(0, 3);
    @(posedge clk);
    axil_req.araddr  <= a;
    axil_req.arvalid <= 1'b1;
    wait_handshake(HS_AR, "read address acceptance");
    @(posedge clk);
    axil_req.arvalid <= 1'b0;
    repeat (delay) @(posedge clk);
    wait_handshake(HS_R, "read data");
    d = axil_rsp.rdata;
    r = axil_rsp.rresp;
    @(posedge clk);
    axil_req.rready <= 1'b1;
    @(posedge clk);
    axil_req.rready <= 1'b0;
  endtask

  //--------------------
  // Model
  //--------------------
  function automatic void model_write(input axil_addr_t a, input axil_data_t d);
    case (a)
      REG_CLK_SEL:  m_sel  = d[SEL_W-1:0];
      REG_CLK_GATE: m_gate = d[NUM_DOMAINS-1:0];
      REG_RST_EN: begin
        m_en     = d[NUM_DOMAINS-1:0];
        m_lockup = d[8];
      end
      default: ;
    endcase
  endfunction

  // Read value with no reset sequence in flight
  function automatic axil_data_t model_read(input axil_addr_t a);
    axil_data_t val;
    val = '0;
    case (a)
      REG_CLK_SEL:  val[SEL_W-1:0] = m_sel;
      REG_CLK_GATE: val[NUM_DOMAINS-1:0] = m_gate;
      REG_RST_EN: begin
        val[NUM_DOMAINS-1:0] = m_en;
        val[8]               = m_lockup;
      end
      REG_RST_STAT: val[NUM_DOMAINS-1:0] = '1;
      default: ;
    endcase
    return val;
  endfunction

  task automatic read_check(input axil_addr_t a);
    axil_read(a, rdata, resp);
    check_value($sformatf("rresp@0x%02h", a), resp, RESP_OKAY);
    check_value($sformatf("rdata@0x%02h", a), rdata, model_read(a));
  endtask

  //--------------------
  // Reset observation
  //--------------------
  task automatic watch_resets(input int cycles);
    logic [NUM_CH-1:0] cur;
    logic [NUM_CH-1:0] prev;
    prev = '1;
    for (int c = 0; c < NUM_CH; c++) begin
      low_cnt[c]  = 0;
      low_runs[c] = 0;
    end
    repeat (cycles) begin
      @(negedge clk);
      cur = {cpu_sys_rst_n, domain_rst_n};
      for (int c = 0; c < NUM_CH; c++) begin
        if (!cur[c]) begin
          low_cnt[c]++;
          if (prev[c]) begin
            low_runs[c]++;
          end
        end
      end
      prev = cur;
    end
  endtask

  task automatic check_resets(input logic [NUM_CH-1:0] exp_low);
    string name;
    for (int c = 0; c < NUM_CH; c++) begin
      name = (c == NUM_DOMAINS) ? "cpu_sys_rst_n" : $sformatf("domain_rst_n[%0d]", c);
      check_value({name, " low cycles"}, low_cnt[c], exp_low[c] ? RST_HOLD : 0);
      check_value({name, " low runs"}, low_runs[c], exp_low[c] ? 1 : 0);
    end
  endtask

  task automatic pulse_source(input int which);
    @(posedge clk);
    case (which)
      0:       sys_reset_req  <= 1'b1;
      1:       wdog_reset_req <= 1'b1;
      default: lockup         <= 1'b1;
    endcase
    @(posedge clk);
    sys_reset_req  <= 1'b0;
    wdog_reset_req <= 1'b0;
    lockup         <= 1'b0;
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    abort_run();
  end

  //--------------------
  // Test sequence
  //--------------------
  initial begin
    void'($urandom(32'h9e339923));
    axil_req       <= '0;
    sys_reset_req  <= 1'b0;
    lockup         <= 1'b0;
    wdog_reset_req <= 1'b0;
    err_cnt  = 0;
    m_sel    = '0;
    m_gate   = '1;
    m_en     = '1;
    m_lockup = 1'b0;

    // Reset state
    @(posedge arst_n);
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_value("clken", clken, 4'hF);
    check_value("domain_rst_n", domain_rst_n, 4'hF);
    check_value("cpu_sys_rst_n", cpu_sys_rst_n, 1'b1);
    for (int a = 0; a <= 16; a += 4) begin
      read_check(axil_addr_t'(a));
    end

    // Register access
    for (int i = 0; i < N_REG_ITER; i++) begin
      case ($urandom_range(0, 2))
        0:       addr = REG_CLK_SEL;
        1:       addr = REG_CLK_GATE;
        default: addr = REG_RST_EN;
      endcase
      data = $urandom;
      axil_write(addr, data, resp);
      check_value("bresp", resp, RESP_OKAY);
      model_write(addr, data);
      read_check(addr);
    end
    for (int i = 0; i < N_ERR_ITER; i++) begin
      addr = axil_addr_t'($urandom_range(8'h14, 8'hFF));
      axil_write(addr, $urandom, resp);
      check_value("bresp unmapped", resp, RESP_SLVERR);
      axil_read(addr, rdata, resp);
      check_value("rresp unmapped", resp, RESP_SLVERR);
      check_value("rdata unmapped", rdata, 32'h0);
    end
    axil_write(REG_RST_STAT, $urandom, resp);
    check_value("bresp RST_STAT", resp, RESP_SLVERR);
    read_check(REG_CLK_SEL);
    read_check(REG_CLK_GATE);
    read_check(REG_RST_EN);

    // Clock enables
    for (int i = 0; i < N_CLK_ITER; i++) begin
      data = $urandom;
      axil_write(REG_CLK_SEL, data, resp);
      check_value("bresp", resp, RESP_OKAY);
      model_write(REG_CLK_SEL, data);
      data = $urandom_range(0, 15);
      axil_write(REG_CLK_GATE, data, resp);
      check_value("bresp", resp, RESP_OKAY);
      model_write(REG_CLK_GATE, data);
      for (int d = 0; d < NUM_DOMAINS; d++) begin
        en_cnt[d] = 0;
      end
      repeat (128) begin
        @(negedge clk);
        for (int d = 0; d < NUM_DOMAINS; d++) begin
          en_cnt[d] += clken[d];
        end
      end
      for (int d = 0; d < NUM_DOMAINS; d++) begin
        check_value($sformatf("clken[%0d] count", d), en_cnt[d],
                    m_gate[d] ? (128 >> m_sel[3*d +: 3]) : 0);
      end
    end

    // Software reset
    for (int i = 0; i < N_SW_ITER; i++) begin
      mask = domain_mask_t'($urandom_range(1, 15));
      fork
        axil_write(REG_RST_REQ, axil_data_t'(mask), resp);
        watch_resets(RST_HOLD + 16);
      join
      check_value("bresp", resp, RESP_OKAY);
      check_resets({1'b0, mask});
      read_check(REG_RST_REQ);
      read_check(REG_RST_STAT);
    end

    // System reset from each of the three sources in turn
    for (int i = 0; i < N_SYS_ITER; i++) begin
      mask    = domain_mask_t'($urandom_range(0, 15));
      lock_en = 1'((i / 3) % 2);
      src     = i % 3;
      data    = axil_data_t'(mask) | (axil_data_t'(lock_en) << 8);
      axil_write(REG_RST_EN, data, resp);
      check_value("bresp", resp, RESP_OKAY);
      model_write(REG_RST_EN, data);
      fork
        pulse_source(src);
        watch_resets(RST_HOLD + 8);
      join
      if (src == 2 && !lock_en) begin
        check_resets('0);
      end else begin
        check_resets({1'b1, mask});
      end
    end

    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

`default_nettype wire

/* verilog/domain_rst_seq.sv */
//--------------------
// Reset sequencer. Synchronizes the power-on reset release, merges
// the system reset sources and holds each domain reset, plus the
// CPU system reset, low for RST_HOLD_CYCLES after a trigger.
// Domain sequencers acknowledge in the cycle their reset rises.
//--------------------
`default_nettype none

module domain_rst_seq #(
  parameter int RST_HOLD_CYCLES = 8
) (
  input  wire logic                        master_clk,
  input  wire logic                        arst_n,
  input  wire plat_ctrl_pkg::rst_cfg_t     rst_cfg,
  input  wire logic                        sys_reset_req,
  input  wire logic                        lockup,
  input  wire logic                        wdog_reset_req,
  output wire logic                        sync_rst_n,
  output plat_ctrl_pkg::domain_mask_t      rst_ack,
  output wire plat_ctrl_pkg::domain_mask_t domain_rst_n,
  output wire logic                        cpu_sys_rst_n
);
  import plat_ctrl_pkg::*;

  // Domain channels first, CPU channel on top
  localparam int NUM_CH = NUM_DOMAINS + 1;
  localparam int CNT_W  = (RST_HOLD_CYCLES > 1) ? $clog2(RST_HOLD_CYCLES) : 1;
  localparam logic [CNT_W-1:0] HOLD_LOAD = CNT_W'(RST_HOLD_CYCLES - 1);

  typedef enum logic {
    IDLE,
    HOLD
  } seq_state_e;

  logic [1:0]        rst_sync_q;
  logic              sys_req;
  logic              sys_req_q;
  logic              sys_edge;
  wire  [NUM_CH-1:0] trig;
  wire  [NUM_CH-1:0] leave;
  wire  [NUM_CH-1:0] rst_n_w;

  //--------------------
  // Power-on reset synchronizer
  //--------------------
  always_ff @(posedge master_clk or negedge arst_n) begin
    if (!arst_n) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign sync_rst_n = rst_sync_q[1];

  // System reset sources, lockup only when enabled
  assign sys_req  = sys_reset_req || wdog_reset_req || (lockup && rst_cfg.lockup_rst_en);
  assign sys_edge = sys_req && !sys_req_q;

  always_ff @(posedge master_clk or negedge arst_n) begin
    if (!arst_n) begin
      sys_req_q <= 1'b0;
    end else begin
      sys_req_q <= sys_req;
    end
  end

  assign trig = {sys_edge, rst_cfg.sw_rst_req | (rst_cfg.sys_rst_en & {NUM_DOMAINS{sys_edge}})};

  //--------------------
  // Hold sequencers
  //--------------------
  for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
    seq_state_e       state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             rst_n_q;
    logic             hold_next;

    assign leave[g]   = (state_q == HOLD) && (cnt_q == '0);
    // Triggers while holding are dropped
    assign hold_next  = (state_q == IDLE) ? trig[g] : (cnt_q != '0);
    assign rst_n_w[g] = rst_n_q;

    always_ff @(posedge master_clk or negedge arst_n) begin
      if (!arst_n) begin
        state_q <= IDLE;
        cnt_q   <= '0;
        rst_n_q <= 1'b0;
      end else begin
        // Release tracks the first synchronizer stage
        rst_n_q <= rst_sync_q[0] && !hold_next;
        case (state_q)
          IDLE: begin
            if (trig[g]) begin
              state_q <= HOLD;
              cnt_q   <= HOLD_LOAD;
            end
          end
          HOLD: begin
            if (cnt_q == '0) begin
              state_q <= IDLE;
            end else begin
              cnt_q <= cnt_q - CNT_W'(1);
            end
          end
          default: state_q <= IDLE;
        endcase
      end
    end

    a_hold_len: assert property (@(posedge master_clk) disable iff (!sync_rst_n)
      $fell(rst_n_w[g]) |-> ##[1:RST_HOLD_CYCLES] rst_n_w[g])
      else $error("reset channel %0d held too long", g);
  end

  // Ack lines up with the rising reset
  always_ff @(posedge master_clk or negedge arst_n) begin
    if (!arst_n) begin
      rst_ack <= '0;
    end else begin
      rst_ack <= leave[NUM_DOMAINS-1:0];
    end
  end

  assign domain_rst_n  = rst_n_w[NUM_DOMAINS-1:0];
  assign cpu_sys_rst_n = rst_n_w[NUM_DOMAINS];

  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : g_ack_chk
    a_ack_on_release: assert property (@(posedge master_clk) disable iff (!sync_rst_n)
      rst_ack[d] |-> domain_rst_n[d] && $past(!domain_rst_n[d]))
      else $error("rst_ack %0d without reset release", d);
  end

endmodule

`default_nettype wire

/* verilog/periph_clken_gen.sv */
//--------------------
// Clock-enable qualifiers for the peripheral domains. Each domain
// pulses its clken for one master cycle every 2**sel cycles while
// its gate bit is set.
//--------------------
`default_nettype none

module periph_clken_gen (
  input  wire logic                        master_clk,
  input  wire logic                        sync_rst_n,
  input  wire plat_ctrl_pkg::clk_cfg_t     clk_cfg,
  output wire plat_ctrl_pkg::domain_mask_t clken
);
  import plat_ctrl_pkg::*;

  // Wide enough for the largest period
  localparam int CNT_W = 2 ** $bits(clk_div_sel_t) - 1;

  for (genvar g = 0; g < NUM_DOMAINS; g++) begin : g_dom
    clk_div_sel_t     sel_q;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_eff;
    logic [CNT_W-1:0] div_mask;

    // Select change restarts the period in the same cycle
    assign cnt_eff = (clk_cfg.sel[g] != sel_q) ? '0 : cnt_q;

    // Top select wraps the shift to zero, giving an all-ones mask
    assign div_mask = (CNT_W'(1) << clk_cfg.sel[g]) - CNT_W'(1);

    assign clken[g] = clk_cfg.gate[g] && ((cnt_eff & div_mask) == '0);

    always_ff @(posedge master_clk or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
        sel_q <= '0;
        cnt_q <= '0;
      end else begin
        sel_q <= clk_cfg.sel[g];
        cnt_q <= cnt_eff + CNT_W'(1);
      end
    end

    // Qualifier lasts one cycle unless the select moves
    a_one_cycle: assert property (@(posedge master_clk) disable iff (!sync_rst_n)
      clken[g] && (clk_cfg.sel[g] != '0)
      |=> !clken[g] || (clk_cfg.sel[g] != $past(clk_cfg.sel[g])))
      else $error("clken %0d high on back-to-back cycles", g);
  end

endmodule

`default_nettype wire

/* verilog/plat_ctrl_pkg.sv */
//--------------------
// Shared definitions for the platform controller: domain count,
// AXI4-Lite request and response structs, register offsets and
// the clock and reset configuration structs passed between blocks.
// Import inside module bodies; port lists use scoped names.
//--------------------
`default_nettype none

package plat_ctrl_pkg;

  // Bit order: timer0, timer1, uart0, wdog
  localparam int NUM_DOMAINS = 4;

  typedef logic [NUM_DOMAINS-1:0] domain_mask_t;
  // Enable period is 2**sel master cycles
  typedef logic [2:0]             clk_div_sel_t;

  //--------------------
  // AXI4-Lite
  //--------------------
  typedef logic [7:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [1:0]  axil_resp_t;

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  typedef struct packed {
    axil_addr_t                      awaddr;
    logic                            awvalid;
    axil_data_t                      wdata;
    logic [$bits(axil_data_t)/8-1:0] wstrb;
    logic                            wvalid;
    logic                            bready;
    axil_addr_t                      araddr;
    logic                            arvalid;
    logic                            rready;
  } axil_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_t bresp;
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    axil_resp_t rresp;
  } axil_rsp_t;

  //--------------------
  // Register map
  //--------------------
  localparam axil_addr_t REG_CLK_SEL  = 8'h00;
  localparam axil_addr_t REG_CLK_GATE = 8'h04;
  localparam axil_addr_t REG_RST_EN   = 8'h08;
  localparam axil_addr_t REG_RST_REQ  = 8'h0C;
  localparam axil_addr_t REG_RST_STAT = 8'h10;

  // Gate bit 1 means the domain runs
  typedef struct packed {
    clk_div_sel_t [NUM_DOMAINS-1:0] sel;
    domain_mask_t                   gate;
  } clk_cfg_t;

  typedef struct packed {
    domain_mask_t sys_rst_en;
    logic         lockup_rst_en;
    domain_mask_t sw_rst_req;
  } rst_cfg_t;

endpackage

`default_nettype wire

/* verilog/plat_ctrl_regs.sv */
//--------------------
// AXI4-Lite register block for the platform controller. Holds the
// divide selects, gate mask, system reset enables and pending
// software reset requests, and hands them out as config structs.
// One write and one read may be outstanding at a time.
//--------------------
`default_nettype none

module plat_ctrl_regs (
  input  wire logic                       master_clk,
  input  wire logic                       sync_rst_n,
  input  wire plat_ctrl_pkg::axil_req_t   axil_req,
  output plat_ctrl_pkg::axil_rsp_t        axil_rsp,
  output plat_ctrl_pkg::clk_cfg_t         clk_cfg,
  output plat_ctrl_pkg::rst_cfg_t         rst_cfg,
  input  wire plat_ctrl_pkg::domain_mask_t rst_ack,
  input  wire plat_ctrl_pkg::domain_mask_t domain_rst_n
);
  import plat_ctrl_pkg::*;

  localparam int SEL_W      = NUM_DOMAINS * $bits(clk_div_sel_t);
  localparam int STRB_W     = $bits(axil_data_t) / 8;
  localparam int LOCKUP_BIT = 8;

  // Handshakes and response state
  logic       aw_hs;
  logic       ar_hs;
  logic       bvalid_q;
  logic       rvalid_q;
  axil_resp_t bresp_q;
  axil_resp_t rresp_q;
  axil_data_t rdata_q;

  // Control registers
  clk_div_sel_t [NUM_DOMAINS-1:0] clk_sel_q;
  domain_mask_t clk_gate_q;
  domain_mask_t sys_rst_en_q;
  logic         lockup_en_q;
  domain_mask_t rst_pend_q;
  domain_mask_t sw_req_q;

  axil_data_t wmask;
  axil_data_t en_cur;
  axil_data_t sel_new;
  axil_data_t gate_new;
  axil_data_t en_new;
  axil_data_t req_new;
  axil_data_t rd_val;
  logic       wr_ok;
  logic       rd_ok;

  function automatic axil_data_t merge_wr(axil_data_t cur, axil_data_t wdata, axil_data_t mask);
    return (cur & ~mask) | (wdata & mask);
  endfunction

  assign aw_hs = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
  assign ar_hs = axil_req.arvalid && !rvalid_q;

  //--------------------
  // Write data
  //--------------------
  always_comb begin
    for (int i = 0; i < STRB_W; i++) begin
      wmask[8*i +: 8] = {8{axil_req.wstrb[i]}};
    end
    en_cur             = axil_data_t'(sys_rst_en_q);
    en_cur[LOCKUP_BIT] = lockup_en_q;
    sel_new  = merge_wr(axil_data_t'(clk_sel_q), axil_req.wdata, wmask);
    gate_new = merge_wr(axil_data_t'(clk_gate_q), axil_req.wdata, wmask);
    en_new   = merge_wr(en_cur, axil_req.wdata, wmask);
    // Request register is write-one, so only set bits count
    req_new  = axil_req.wdata & wmask;
    wr_ok    = (axil_req.awaddr == REG_CLK_SEL) || (axil_req.awaddr == REG_CLK_GATE) ||
               (axil_req.awaddr == REG_RST_EN) || (axil_req.awaddr == REG_RST_REQ);
  end

  always_ff @(posedge master_clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      clk_sel_q    <= '0;
      clk_gate_q   <= '1;
      sys_rst_en_q <= '1;
      lockup_en_q  <= 1'b0;
      rst_pend_q   <= '0;
      sw_req_q     <= '0;
    end else begin
      sw_req_q   <= '0;
      rst_pend_q <= rst_pend_q & ~rst_ack;
      if (aw_hs) begin
        case (axil_req.awaddr)
          REG_CLK_SEL:  clk_sel_q  <= SEL_W'(sel_new);
          REG_CLK_GATE: clk_gate_q <= domain_mask_t'(gate_new);
          REG_RST_EN: begin
            sys_rst_en_q <= domain_mask_t'(en_new);
            lockup_en_q  <= en_new[LOCKUP_BIT];
          end
          REG_RST_REQ: begin
            // Pulse to the sequencer, pending until acknowledged
            sw_req_q   <= domain_mask_t'(req_new);
            rst_pend_q <= (rst_pend_q & ~rst_ack) | domain_mask_t'(req_new);
          end
          default: ;
        endcase
      end
    end
  end

  //--------------------
  // Read data
  //--------------------
  always_comb begin
    rd_val = '0;
    rd_ok  = 1'b1;
    case (axil_req.araddr)
      REG_CLK_SEL:  rd_val = axil_data_t'(clk_sel_q);
      REG_CLK_GATE: rd_val = axil_data_t'(clk_gate_q);
      REG_RST_EN:   rd_val = en_cur;
      REG_RST_REQ:  rd_val = axil_data_t'(rst_pend_q);
      REG_RST_STAT: rd_val = axil_data_t'(domain_rst_n);
      default:      rd_ok  = 1'b0;
    endcase
  end

  // Valid flags, held until the manager takes the response
  always_ff @(posedge master_clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (aw_hs) begin
        bvalid_q <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
      if (ar_hs) begin
        rvalid_q <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge master_clk) begin
    if (aw_hs) begin
      bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end
    if (ar_hs) begin
      rdata_q <= rd_val;
      rresp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  always_comb begin
    axil_rsp         = '0;
    axil_rsp.awready = aw_hs;
    axil_rsp.wready  = aw_hs;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.bresp   = bresp_q;
    axil_rsp.arready = ar_hs;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;

    clk_cfg.sel  = clk_sel_q;
    clk_cfg.gate = clk_gate_q;

    rst_cfg.sys_rst_en    = sys_rst_en_q;
    rst_cfg.lockup_rst_en = lockup_en_q;
    rst_cfg.sw_rst_req    = sw_req_q;
  end

  a_bvalid_hold: assert property (@(posedge master_clk) disable iff (!sync_rst_n)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
    else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (@(posedge master_clk) disable iff (!sync_rst_n)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
    else $error("rvalid dropped before rready");

endmodule

`default_nettype wire

/* verilog/plat_ctrl_top.sv */
//--------------------
// Platform controller top. Ties the AXI4-Lite register block to
// the clock-enable generator and the reset sequencer, all running
// on master_clk. RST_HOLD_CYCLES sets the sequenced reset width.
//--------------------
`default_nettype none

module plat_ctrl_top #(
  parameter int RST_HOLD_CYCLES = 8
) (
  input  wire logic                        master_clk,
  input  wire logic                        arst_n,
  input  wire plat_ctrl_pkg::axil_req_t    axil_req,
  output wire plat_ctrl_pkg::axil_rsp_t    axil_rsp,
  input  wire logic                        sys_reset_req,
  input  wire logic                        lockup,
  input  wire logic                        wdog_reset_req,
  output wire plat_ctrl_pkg::domain_mask_t clken,
  output wire plat_ctrl_pkg::domain_mask_t domain_rst_n,
  output wire logic                        cpu_sys_rst_n
);
  import plat_ctrl_pkg::*;

  logic         sync_rst_n;
  clk_cfg_t     clk_cfg;
  rst_cfg_t     rst_cfg;
  domain_mask_t rst_ack;

  //--------------------
  // Register block
  //--------------------
  plat_ctrl_regs u_regs (
    .master_clk   (master_clk),
    .sync_rst_n   (sync_rst_n),
    .axil_req     (axil_req),
    .axil_rsp     (axil_rsp),
    .clk_cfg      (clk_cfg),
    .rst_cfg      (rst_cfg),
    .rst_ack      (rst_ack),
    .domain_rst_n (domain_rst_n)
  );

  // Peripheral clock qualifiers
  periph_clken_gen u_clken_gen (
    .master_clk (master_clk),
    .sync_rst_n (sync_rst_n),
    .clk_cfg    (clk_cfg),
    .clken      (clken)
  );

  //--------------------
  // Reset sequencing
  //--------------------
  domain_rst_seq #(
    .RST_HOLD_CYCLES (RST_HOLD_CYCLES)
  ) u_rst_seq (
    .master_clk     (master_clk),
    .arst_n         (arst_n),
    .rst_cfg        (rst_cfg),
    .sys_reset_req  (sys_reset_req),
    .lockup         (lockup),
    .wdog_reset_req (wdog_reset_req),
    .sync_rst_n     (sync_rst_n),
    .rst_ack        (rst_ack),
    .domain_rst_n   (domain_rst_n),
    .cpu_sys_rst_n  (cpu_sys_rst_n)
  );

endmodule

`default_nettype wire
